// ==== build.f ====
hw/elu_pkg.sv
hw/lane_fifo.sv
hw/lane_roller.sv
hw/fixed_elu.sv
hw/elu_apb_regs.sv
hw/elu_act_top.sv
sim/elu_act_chk.sv
sim/tb_elu_act.sv

// ==== hw/elu_act_top.sv ====
`timescale 1ns/10ps
module elu_act_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  elu_pkg::apb_addr_t paddr,
  input  elu_pkg::apb_data_t pwdata,
  output elu_pkg::apb_data_t prdata,
  output logic               pready,
  output logic               pslverr,
  input  elu_pkg::beat_in_t  in_data,
  input  logic               in_valid,
  output logic               in_ready,
  output elu_pkg::beat_out_t out_data,
  output logic               out_valid,
  input  logic               out_ready
);

  logic              enable;
  logic              lut_we;
  elu_pkg::lut_idx_t lut_waddr;
  elu_pkg::fx_t      lut_wdata;
  elu_pkg::lut_idx_t lut_raddr;
  elu_pkg::fx_t      lut_rdata;
  logic              fifo_empty;
  logic              fifo_full;

  elu_apb_regs i_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .enable     (enable),
    .lut_we     (lut_we),
    .lut_waddr  (lut_waddr),
    .lut_wdata  (lut_wdata),
    .lut_raddr  (lut_raddr),
    .lut_rdata  (lut_rdata),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full)
  );

  fixed_elu i_elu (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable     (enable),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .out_data   (out_data),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .lut_we     (lut_we),
    .lut_waddr  (lut_waddr),
    .lut_wdata  (lut_wdata),
    .lut_raddr  (lut_raddr),
    .lut_rdata  (lut_rdata),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full)
  );

endmodule

// ==== hw/elu_apb_regs.sv ====
`timescale 1ns/10ps
module elu_apb_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  elu_pkg::apb_addr_t paddr,
  input  elu_pkg::apb_data_t pwdata,
  output elu_pkg::apb_data_t prdata,
  output logic               pready,
  output logic               pslverr,
  output logic               enable,
  output logic               lut_we,
  output elu_pkg::lut_idx_t  lut_waddr,
  output elu_pkg::fx_t       lut_wdata,
  output elu_pkg::lut_idx_t  lut_raddr,
  input  elu_pkg::fx_t       lut_rdata,
  input  logic               fifo_empty,
  input  logic               fifo_full
);

  logic               access;
  logic               wr_access;
  logic               is_ctrl;
  logic               is_status;
  logic               is_lut;
  elu_pkg::apb_addr_t lut_off;
  elu_pkg::lut_idx_t  lut_idx;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign access    = psel && penable;
  assign wr_access = access && pwrite;

  assign is_ctrl   = (paddr == elu_pkg::REG_CTRL);
  assign is_status = (paddr == elu_pkg::REG_STATUS);
  assign is_lut    = (paddr >= elu_pkg::LUT_BASE) && (paddr <= elu_pkg::LUT_LAST);

  // Word offset into the table
  assign lut_off = paddr - elu_pkg::LUT_BASE;
  assign lut_idx = lut_off[elu_pkg::LUT_IDX_W+1:2];

  // No wait states
  assign pready  = 1'b1;
  assign pslverr = access && !(is_ctrl || is_status || is_lut);

  assign lut_raddr = lut_idx;

  // CTRL register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enable <= 1'b0;
    end else if (wr_access && is_ctrl) begin
      enable <= pwdata[elu_pkg::CTRL_EN_BIT];
    end
  end

  // Table write strobe, one cycle after the access phase
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lut_we <= 1'b0;
    end else begin
      lut_we <= wr_access && is_lut;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_access && is_lut) begin
      lut_waddr <= lut_idx;
      lut_wdata <= pwdata[elu_pkg::DATA_W-1:0];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read data
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      if (is_ctrl) begin
        prdata[elu_pkg::CTRL_EN_BIT] = enable;
      end else if (is_status) begin
        prdata[elu_pkg::STATUS_EMPTY_BIT] = fifo_empty;
        prdata[elu_pkg::STATUS_FULL_BIT]  = fifo_full;
      end else if (is_lut) begin
        prdata[elu_pkg::DATA_W-1:0] = lut_rdata;
      end
    end
  end

endmodule

// ==== hw/elu_pkg.sv ====
package elu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Data path sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int DATA_W     = 8;
  // Lanes are signed Q3.4
  localparam int FRAC_W     = 4;
  localparam int IN_NUM     = 4;
  localparam int ROLL_NUM   = 2;
  localparam int ROLL_STEPS = IN_NUM / ROLL_NUM;
  localparam int ROLL_IDX_W = (ROLL_STEPS > 1) ? $clog2(ROLL_STEPS) : 1;
  localparam int BEAT_IN_W  = IN_NUM * DATA_W;
  localparam int BEAT_OUT_W = ROLL_NUM * DATA_W;
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int LUT_SIZE   = 256;
  localparam int LUT_IDX_W  = $clog2(LUT_SIZE);
  localparam int ADDR_W     = 12;
  localparam int APB_DATA_W = 32;

  typedef logic [DATA_W-1:0]     fx_t;
  typedef logic [LUT_IDX_W-1:0]  lut_idx_t;
  typedef logic [BEAT_IN_W-1:0]  beat_in_t;
  typedef logic [BEAT_OUT_W-1:0] beat_out_t;
  typedef logic [ROLL_IDX_W-1:0] roll_idx_t;
  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;
  typedef logic [ADDR_W-1:0]     apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // APB register map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam apb_addr_t REG_CTRL   = 12'h000;
  localparam apb_addr_t REG_STATUS = 12'h004;
  localparam apb_addr_t LUT_BASE   = 12'h400;
  localparam apb_addr_t LUT_LAST   = LUT_BASE + apb_addr_t'(4 * (LUT_SIZE - 1));

  localparam int CTRL_EN_BIT      = 0;
  localparam int STATUS_EMPTY_BIT = 0;
  localparam int STATUS_FULL_BIT  = 1;

  typedef enum logic {
    ROLL_IDLE,
    ROLL_HOLD
  } roll_state_t;

endpackage

// ==== hw/fixed_elu.sv ====
`timescale 1ns/10ps
module fixed_elu (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               enable,
  input  elu_pkg::beat_in_t  in_data,
  input  logic               in_valid,
  output logic               in_ready,
  output elu_pkg::beat_out_t out_data,
  output logic               out_valid,
  input  logic               out_ready,
  input  logic               lut_we,
  input  elu_pkg::lut_idx_t  lut_waddr,
  input  elu_pkg::fx_t       lut_wdata,
  input  elu_pkg::lut_idx_t  lut_raddr,
  output elu_pkg::fx_t       lut_rdata,
  output logic               fifo_empty,
  output logic               fifo_full
);

  elu_pkg::fx_t       elu_lut [elu_pkg::LUT_SIZE];

  elu_pkg::beat_in_t  ff_data;
  logic               ff_valid;
  logic               ff_ready;
  logic               fifo_in_valid;
  logic               fifo_in_ready;
  elu_pkg::beat_out_t roll_data;

  // Enable only closes the input side
  assign fifo_in_valid = in_valid && enable;
  assign in_ready      = fifo_in_ready && enable;

  lane_fifo i_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (in_data),
    .in_valid  (fifo_in_valid),
    .in_ready  (fifo_in_ready),
    .out_data  (ff_data),
    .out_valid (ff_valid),
    .out_ready (ff_ready),
    .empty     (fifo_empty),
    .full      (fifo_full)
  );

  lane_roller i_roller (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (ff_data),
    .in_valid  (ff_valid),
    .in_ready  (ff_ready),
    .out_data  (roll_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ELU table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (lut_we) begin
      elu_lut[lut_waddr] <= lut_wdata;
    end
  end

  assign lut_rdata = elu_lut[lut_raddr];

  // Raw lane byte is the table index
  for (genvar i = 0; i < elu_pkg::ROLL_NUM; i++) begin : g_lane
    elu_pkg::lut_idx_t lane_idx;

    assign lane_idx = elu_pkg::lut_idx_t'(roll_data[i*elu_pkg::DATA_W +: elu_pkg::DATA_W]);
    assign out_data[i*elu_pkg::DATA_W +: elu_pkg::DATA_W] = elu_lut[lane_idx];
  end

endmodule

// ==== hw/lane_fifo.sv ====
`timescale 1ns/10ps
module lane_fifo (
  input  logic              clk,
  input  logic              rst_n,
  input  elu_pkg::beat_in_t in_data,
  input  logic              in_valid,
  output logic              in_ready,
  output elu_pkg::beat_in_t out_data,
  output logic              out_valid,
  input  logic              out_ready,
  output logic              empty,
  output logic              full
);

  elu_pkg::beat_in_t  mem [elu_pkg::FIFO_DEPTH];
  elu_pkg::fifo_ptr_t wr_ptr;
  elu_pkg::fifo_ptr_t rd_ptr;
  elu_pkg::fifo_cnt_t count;
  logic               wr_en;
  logic               rd_en;

  function automatic elu_pkg::fifo_ptr_t next_ptr(input elu_pkg::fifo_ptr_t ptr);
    if (ptr == elu_pkg::fifo_ptr_t'(elu_pkg::FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Flags from occupancy
  assign empty = (count == '0);
  assign full  = (count == elu_pkg::fifo_cnt_t'(elu_pkg::FIFO_DEPTH));

  assign in_ready  = !full;
  assign out_valid = !empty;
  assign out_data  = mem[rd_ptr];

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  // Beat storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
    end
  end

  // Simultaneous push and pop leaves count alone
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

endmodule

// ==== hw/lane_roller.sv ====
`timescale 1ns/10ps
module lane_roller (
  input  logic               clk,
  input  logic               rst_n,
  input  elu_pkg::beat_in_t  in_data,
  input  logic               in_valid,
  output logic               in_ready,
  output elu_pkg::beat_out_t out_data,
  output logic               out_valid,
  input  logic               out_ready
);

  elu_pkg::roll_state_t state;
  elu_pkg::beat_in_t    beat_q;
  elu_pkg::roll_idx_t   slice_q;
  logic                 last_slice;
  logic                 out_fire;
  logic                 load;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign out_valid  = (state == elu_pkg::ROLL_HOLD);
  assign out_fire   = out_valid && out_ready;
  assign last_slice = (slice_q == elu_pkg::roll_idx_t'(elu_pkg::ROLL_STEPS - 1));

  // Reload on the last slice, no bubble
  assign in_ready = (state == elu_pkg::ROLL_IDLE) || (out_fire && last_slice);
  assign load     = in_valid && in_ready;

  // Current slice always sits in the low lanes
  assign out_data = beat_q[elu_pkg::BEAT_OUT_W-1:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Beat register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (load) begin
      beat_q <= in_data;
    end else if (out_fire && !last_slice) begin
      beat_q <= beat_q >> elu_pkg::BEAT_OUT_W;
    end
  end

  // Slice counter and state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= elu_pkg::ROLL_IDLE;
      slice_q <= '0;
    end else begin
      if (load) begin
        state   <= elu_pkg::ROLL_HOLD;
        slice_q <= '0;
      end else if (out_fire) begin
        if (last_slice) begin
          state   <= elu_pkg::ROLL_IDLE;
          slice_q <= '0;
        end else begin
          slice_q <= slice_q + 1'b1;
        end
      end
    end
  end

endmodule

// ==== sim/elu_act_chk.sv ====
`timescale 1ns/10ps
module elu_act_chk (
  input logic               clk,
  input logic               rst_n,
  input logic               pwrite,
  input logic               pslverr,
  input logic               enable,
  input logic               lut_we,
  input elu_pkg::beat_in_t  in_data,
  input logic               in_valid,
  input logic               in_ready,
  input elu_pkg::beat_out_t out_data,
  input logic               out_valid,
  input logic               out_ready
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stream stability under back-pressure
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("out_data or out_valid changed while stalled");

  a_in_stable: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid && $stable(in_data))
    else $error("in_data or in_valid changed while stalled");

  // Unmapped write leaves CTRL and the table alone
  a_slverr_no_effect: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr && pwrite |=> $stable(enable) && !lut_we)
    else $error("write to an unmapped address changed CTRL or the table");

  // Second reset cycle onwards, state is known
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n && $past(!rst_n) |-> !out_valid)
    else $error("out_valid high during reset");

endmodule

bind elu_act_top elu_act_chk i_chk (.*);

// ==== sim/tb_elu_act.sv ====
`timescale 1ns/10ps
module tb_elu_act;

  localparam int STREAM_BEATS = 300;
  // Roughly 5k cycles of tests, four times that as margin
  localparam int MAX_CYCLES   = 20000;

  logic               clk;
  logic               rst_n;
  logic               psel;
  logic               penable;
  logic               pwrite;
  elu_pkg::apb_addr_t paddr;
  elu_pkg::apb_data_t pwdata;
  elu_pkg::apb_data_t prdata;
  logic               pready;
  logic               pslverr;
  elu_pkg::beat_in_t  in_data;
  logic               in_valid;
  logic               in_ready;
  elu_pkg::beat_out_t out_data;
  logic               out_valid;
  logic               out_ready;

  integer             seed = 32'hc126a438;
  int                 cycle_cnt = 0;
  int                 in_cnt = 0;
  int                 out_cnt = 0;
  elu_pkg::fx_t       model_lut [elu_pkg::LUT_SIZE];
  elu_pkg::beat_out_t exp_q [$];

  elu_act_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Failure handling and value checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic stop_with_failure();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      stop_with_failure();
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input lane step*ROLL_NUM+l lands in lane l of output beat step
  function automatic elu_pkg::beat_out_t map_slice(input elu_pkg::beat_in_t beat, input int step);
    elu_pkg::beat_out_t res;
    elu_pkg::fx_t       lane_val;
    for (int l = 0; l < elu_pkg::ROLL_NUM; l++) begin
      lane_val = beat[(step * elu_pkg::ROLL_NUM + l) * elu_pkg::DATA_W +: elu_pkg::DATA_W];
      res[l * elu_pkg::DATA_W +: elu_pkg::DATA_W] = model_lut[lane_val];
    end
    return res;
  endfunction

  always @(posedge clk) begin
    if (rst_n) begin
      if (in_valid && in_ready) begin
        for (int s = 0; s < elu_pkg::ROLL_STEPS; s++) begin
          exp_q.push_back(map_slice(in_data, s));
        end
        in_cnt++;
      end
      if (out_valid && out_ready) begin
        assert (exp_q.size() > 0) else begin
          $display("An output beat appeared with no input beat pending at t=%0t", $time);
          stop_with_failure();
        end
        check_value("out_data", exp_q[0], out_data);
        void'(exp_q.pop_front());
        out_cnt++;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // APB driver
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic apb_access(input logic wr, input elu_pkg::apb_addr_t addr,
                            input elu_pkg::apb_data_t wdata,
                            output elu_pkg::apb_data_t rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    rdata = prdata;
    err   = pslverr;
    check_value("pready", 1, pready);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic reg_write(input elu_pkg::apb_addr_t addr, input elu_pkg::apb_data_t data);
    elu_pkg::apb_data_t rd;
    logic               err;
    apb_access(1'b1, addr, data, rd, err);
    check_value("pslverr", 0, err);
  endtask

  task automatic reg_read(input elu_pkg::apb_addr_t addr, output elu_pkg::apb_data_t data);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check_value("pslverr", 0, err);
  endtask

  function automatic elu_pkg::apb_addr_t lut_addr(input int k);
    return elu_pkg::apb_addr_t'(elu_pkg::LUT_BASE + 4 * k);
  endfunction

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    elu_pkg::apb_data_t rd;
    elu_pkg::apb_addr_t bad_addr [4];
    logic               err;
    logic               full_seen;
    int                 sent;
    int                 n;
    int                 idx;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    in_data   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    bad_addr  = '{12'h008, 12'h200, 12'h00c, 12'h800};
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // After reset
    check_value("in_ready", 0, in_ready);
    check_value("out_valid", 0, out_valid);
    reg_read(elu_pkg::REG_CTRL, rd);
    check_value("CTRL", 0, rd);
    reg_read(elu_pkg::REG_STATUS, rd);
    check_value("STATUS", 1, rd);

    // Table load and readback
    for (int k = 0; k < elu_pkg::LUT_SIZE; k++) begin
      model_lut[k] = elu_pkg::fx_t'($random(seed));
      reg_write(lut_addr(k), elu_pkg::apb_data_t'(model_lut[k]));
    end
    for (int i = 0; i < 32; i++) begin
      idx = $random(seed) & 8'hff;
      reg_read(lut_addr(idx), rd);
      check_value("LUT readback", model_lut[idx], rd);
    end
    reg_write(elu_pkg::REG_CTRL, 1);
    reg_read(elu_pkg::REG_CTRL, rd);
    check_value("CTRL", 1, rd);

    // Random stream under random back-pressure
    sent = 0;
    while (sent < STREAM_BEATS || in_valid) begin
      @(posedge clk);
      if (in_valid && in_ready) begin
        sent++;
      end
      if (!in_valid || in_ready) begin
        if (sent < STREAM_BEATS && ($random(seed) & 1)) begin
          in_valid <= 1'b1;
          in_data  <= elu_pkg::beat_in_t'($random(seed));
        end else begin
          in_valid <= 1'b0;
        end
      end
      out_ready <= (($random(seed) & 32'hff) < 179);
    end
    out_ready <= 1'b1;
    wait_drained();
    check_value("accepted beats", STREAM_BEATS, in_cnt);

    // FIFO fill with output stalled, roller holds one beat too
    out_ready <= 1'b0;
    in_valid  <= 1'b1;
    in_data   <= elu_pkg::beat_in_t'($random(seed));
    n = 0;
    full_seen = 1'b0;
    for (int i = 0; i < 4 * elu_pkg::FIFO_DEPTH && !full_seen; i++) begin
      @(posedge clk);
      if (in_ready) begin
        n++;
        in_data <= elu_pkg::beat_in_t'($random(seed));
      end else begin
        full_seen = 1'b1;
      end
    end
    assert (full_seen) else begin
      $display("in_ready never fell while the output was stalled");
      stop_with_failure();
    end
    check_value("beats before full", elu_pkg::FIFO_DEPTH + 1, n);
    reg_read(elu_pkg::REG_STATUS, rd);
    check_value("STATUS", 2, rd);
    out_ready <= 1'b1;
    do @(posedge clk); while (!in_ready);
    in_valid <= 1'b0;
    wait_drained();
    reg_read(elu_pkg::REG_STATUS, rd);
    check_value("STATUS", 1, rd);

    // Disable with beats buffered
    out_ready <= 1'b0;
    in_valid  <= 1'b1;
    in_data   <= elu_pkg::beat_in_t'($random(seed));
    n = 0;
    while (n < 4) begin
      @(posedge clk);
      if (in_ready) begin
        n++;
        if (n < 4) begin
          in_data <= elu_pkg::beat_in_t'($random(seed));
        end else begin
          in_valid <= 1'b0;
        end
      end
    end
    reg_write(elu_pkg::REG_CTRL, 0);
    in_valid  <= 1'b1;
    in_data   <= elu_pkg::beat_in_t'($random(seed));
    out_ready <= 1'b1;
    // Buffered beats drain while the input stays closed
    while (exp_q.size() != 0) begin
      @(posedge clk);
      check_value("in_ready", 0, in_ready);
    end
    repeat (10) begin
      @(posedge clk);
      check_value("in_ready", 0, in_ready);
      check_value("out_valid", 0, out_valid);
    end
    reg_write(elu_pkg::REG_CTRL, 1);
    do @(posedge clk); while (!in_ready);
    in_valid <= 1'b0;
    wait_drained();

    // Unmapped addresses
    foreach (bad_addr[i]) begin
      apb_access(1'b1, bad_addr[i], 32'h0, rd, err);
      check_value("pslverr", 1, err);
      apb_access(1'b0, bad_addr[i], 32'h0, rd, err);
      check_value("pslverr", 1, err);
      check_value("prdata", 0, rd);
    end
    reg_read(elu_pkg::REG_CTRL, rd);
    check_value("CTRL", 1, rd);
    for (int k = 0; k < elu_pkg::LUT_SIZE; k++) begin
      reg_read(lut_addr(k), rd);
      check_value("LUT readback", model_lut[k], rd);
    end

    check_value("output beats", elu_pkg::ROLL_STEPS * in_cnt, out_cnt);
    $display("Simulation PASSED");
    $finish;
  end

endmodule
